// ==== hw/idctPkg.sv ====
// idct shared definitions
// widths, value types, sequencer states and the fixed-point cosine table

package idctPkg;

   parameter int BlockDim = 8;
   parameter int WordWidth = 32;
   parameter int CoefWidth = 16;
   parameter int AccWidth = 44;
   parameter int PassShift = 16;

   typedef logic signed [WordWidth-1:0] wordT;
   typedef logic [5:0] addrT;
   typedef logic signed [CoefWidth-1:0] coefT;
   typedef logic signed [AccWidth-1:0] accT;

   typedef enum logic [2:0]
   {
      idle,
      load,
      rowPass,
      rowDrain,
      colPass,
      colDrain,
      unload
   } seqStateT;

   // entry x*8+u holds c(u)*cos((2x+1)u*pi/16) in Q15
   parameter coefT cosTable [64] = '{
      16'sd23170,  16'sd32138,  16'sd30274,  16'sd27246,
      16'sd23170,  16'sd18205,  16'sd12540,  16'sd6393,
      16'sd23170,  16'sd27246,  16'sd12540, -16'sd6393,
     -16'sd23170, -16'sd32138, -16'sd30274, -16'sd18205,
      16'sd23170,  16'sd18205, -16'sd12540, -16'sd32138,
     -16'sd23170,  16'sd6393,   16'sd30274,  16'sd27246,
      16'sd23170,  16'sd6393,  -16'sd30274, -16'sd18205,
      16'sd23170,  16'sd27246, -16'sd12540, -16'sd32138,
      16'sd23170, -16'sd6393,  -16'sd30274,  16'sd18205,
      16'sd23170, -16'sd27246, -16'sd12540,  16'sd32138,
      16'sd23170, -16'sd18205, -16'sd12540,  16'sd32138,
     -16'sd23170, -16'sd6393,   16'sd30274, -16'sd27246,
      16'sd23170, -16'sd27246,  16'sd12540,  16'sd6393,
     -16'sd23170,  16'sd32138, -16'sd30274,  16'sd18205,
      16'sd23170, -16'sd32138,  16'sd30274, -16'sd27246,
      16'sd23170, -16'sd18205,  16'sd12540, -16'sd6393
   };

endpackage

// ==== hw/idctMacIf.sv ====
// operand and result channel between the sequencer and the MAC unit
// one operand per valid cycle, one result per closed sum

interface idctMacIf;

   // operand side
   logic          opValid;
   logic          opFirst;
   logic          opLast;
   idctPkg::wordT operand;
   idctPkg::addrT coefIdx;
   idctPkg::addrT dstAddr;

   // result side
   logic          resValid;
   idctPkg::wordT result;
   idctPkg::addrT resAddr;

   modport seq (
      output opValid, opFirst, opLast, operand, coefIdx, dstAddr,
      input  resValid, result, resAddr
   );

   modport mac (
      input  opValid, opFirst, opLast, operand, coefIdx, dstAddr,
      output resValid, result, resAddr
   );

endinterface

// ==== hw/blockBuffer.sv ====
// single-port block memory
// synchronous write, registered read, one word per address

module blockBuffer #(
   parameter int Depth = 64
) (
   input  logic          clk,
   input  idctPkg::addrT addr,
   input  idctPkg::wordT wdata,
   input  logic          we,
   output idctPkg::wordT rdata
);

   idctPkg::wordT mem [Depth];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
      end
      // read returns the old word on a write cycle
      rdata <= mem[addr];
   end

endmodule

// ==== hw/idctMac.sv ====
// shared multiply-accumulate unit for both idct passes
// coefficient lookup, signed multiply, accumulate, then scale on the last term
// three cycles from operand to result

module idctMac (
   input logic   clk,
   input logic   racc,
   idctMacIf.mac mac
);

   idctPkg::wordT operandReg;
   idctPkg::coefT coefReg;
   idctPkg::addrT dst1;
   idctPkg::addrT dst2;
   idctPkg::accT  prod;
   idctPkg::accT  acc;
   idctPkg::accT  accNext;
   logic          valid1;
   logic          valid2;
   logic          first1;
   logic          first2;
   logic          last1;
   logic          last2;

   // first term restarts the sum
   assign accNext = first2 ? prod : acc + prod;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         valid1 <= 1'b0;
         valid2 <= 1'b0;
         first1 <= 1'b0;
         first2 <= 1'b0;
         last1 <= 1'b0;
         last2 <= 1'b0;
         mac.resValid <= 1'b0;
      end
      else
      begin
         valid1 <= mac.opValid;
         first1 <= mac.opFirst;
         last1 <= mac.opLast;
         valid2 <= valid1;
         first2 <= first1;
         last2 <= last1;
         mac.resValid <= valid2 && last2;
      end
   end

   always_ff @(posedge clk)
   begin
      operandReg <= mac.operand;
      coefReg <= idctPkg::cosTable[mac.coefIdx];
      dst1 <= mac.dstAddr;
      prod <= idctPkg::accT'(operandReg) * idctPkg::accT'(coefReg);
      dst2 <= dst1;
      if (valid2)
      begin
         acc <= accNext;
      end
      if (valid2 && last2)
      begin
         mac.result <= idctPkg::wordT'(accNext >>> idctPkg::PassShift);
         mac.resAddr <= dst2;
      end
   end

endmodule

// ==== hw/idctSequencer.sv ====
// idct sequencer
// orders the block load, the row and column passes and the unload,
// steering the three block buffers and feeding the MAC unit

module idctSequencer (
   input  logic          clk,
   input  logic          racc,
   input  logic          start,
   input  idctPkg::wordT din,
   output logic          reading,
   output logic          done,
   output idctPkg::wordT dout,
   output idctPkg::addrT inAddr,
   output idctPkg::wordT inWdata,
   output logic          inWe,
   input  idctPkg::wordT inRdata,
   output idctPkg::addrT tempAddr,
   output idctPkg::wordT tempWdata,
   output logic          tempWe,
   input  idctPkg::wordT tempRdata,
   output idctPkg::addrT outAddr,
   output idctPkg::wordT outWdata,
   output logic          outWe,
   input  idctPkg::wordT outRdata,
   idctMacIf.seq         mac
);

   idctPkg::seqStateT state;
   logic [8:0]        cnt;
   logic [2:0]        i;
   logic [2:0]        j;
   logic [2:0]        k;
   logic              inRowPass;
   logic              inColPass;
   logic              lastResult;

   // i and j pick the output element, k the term
   assign i = cnt[8:6];
   assign j = cnt[5:3];
   assign k = cnt[2:0];

   // a pass keeps writing results through its drain state
   assign inRowPass = (state == idctPkg::rowPass) || (state == idctPkg::rowDrain);
   assign inColPass = (state == idctPkg::colPass) || (state == idctPkg::colDrain);
   assign lastResult = mac.resValid && (&mac.resAddr);

   assign reading = (state == idctPkg::load);

   // input block: samples in during load, row operands afterwards
   assign inAddr = reading ? cnt[5:0] : {i, k};
   assign inWdata = din;
   assign inWe = reading;

   // temp block: row results in, column operands out
   assign tempAddr = (state == idctPkg::colPass) ? {k, j} : mac.resAddr;
   assign tempWdata = mac.result;
   assign tempWe = mac.resValid && inRowPass;

   // output block: column results in, unload reads out
   assign outAddr = (state == idctPkg::unload) ? cnt[5:0] : mac.resAddr;
   assign outWdata = mac.result;
   assign outWe = mac.resValid && inColPass;

   // buffer read data lines up with the issue registers below
   assign mac.operand = inColPass ? tempRdata : inRdata;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         state <= idctPkg::idle;
         cnt <= '0;
         done <= 1'b0;
         dout <= '0;
      end
      else
      begin
         case (state)
            idctPkg::idle:
            begin
               done <= 1'b0;
               if (start)
                  state <= idctPkg::load;
            end
            idctPkg::load:
            begin
               cnt <= cnt + 9'd1;
               if (cnt == 9'd63)
               begin
                  cnt <= '0;
                  state <= idctPkg::rowPass;
               end
            end
            idctPkg::rowPass:
            begin
               // counter wraps to zero after the last term
               cnt <= cnt + 9'd1;
               if (&cnt)
                  state <= idctPkg::rowDrain;
            end
            idctPkg::rowDrain:
            begin
               if (lastResult)
                  state <= idctPkg::colPass;
            end
            idctPkg::colPass:
            begin
               cnt <= cnt + 9'd1;
               if (&cnt)
                  state <= idctPkg::colDrain;
            end
            idctPkg::colDrain:
            begin
               if (lastResult)
                  state <= idctPkg::unload;
            end
            idctPkg::unload:
            begin
               // address runs one ahead of dout
               cnt <= cnt + 9'd1;
               if (cnt != 9'd0)
               begin
                  done <= 1'b1;
                  dout <= outRdata;
               end
               if (cnt == 9'd64)
               begin
                  cnt <= '0;
                  state <= idctPkg::idle;
               end
            end
            default:
               state <= idctPkg::idle;
         endcase
      end
   end

   // issue stage, one cycle behind the buffer address
   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         mac.opValid <= 1'b0;
         mac.opFirst <= 1'b0;
         mac.opLast <= 1'b0;
      end
      else
      begin
         mac.opValid <= (state == idctPkg::rowPass) || (state == idctPkg::colPass);
         mac.opFirst <= (k == 3'd0);
         mac.opLast <= (k == 3'd7);
      end
   end

   always_ff @(posedge clk)
   begin
      mac.coefIdx <= (state == idctPkg::colPass) ? {i, k} : {j, k};
      mac.dstAddr <= {i, j};
   end

endmodule

// ==== hw/idct.sv ====
// 8x8 two-dimensional inverse DCT
// streams a block in, runs row and column passes on one shared MAC, streams it out

module idct (
   input  logic          clk,
   input  logic          racc,
   input  logic          start,
   input  idctPkg::wordT din,
   output logic          reading,
   output logic          done,
   output idctPkg::wordT dout
);

   idctPkg::addrT inAddr;
   idctPkg::wordT inWdata;
   logic          inWe;
   idctPkg::wordT inRdata;
   idctPkg::addrT tempAddr;
   idctPkg::wordT tempWdata;
   logic          tempWe;
   idctPkg::wordT tempRdata;
   idctPkg::addrT outAddr;
   idctPkg::wordT outWdata;
   logic          outWe;
   idctPkg::wordT outRdata;

   idctMacIf macBus ();

   idctSequencer sequencer (
      .clk       (clk),
      .racc      (racc),
      .start     (start),
      .din       (din),
      .reading   (reading),
      .done      (done),
      .dout      (dout),
      .inAddr    (inAddr),
      .inWdata   (inWdata),
      .inWe      (inWe),
      .inRdata   (inRdata),
      .tempAddr  (tempAddr),
      .tempWdata (tempWdata),
      .tempWe    (tempWe),
      .tempRdata (tempRdata),
      .outAddr   (outAddr),
      .outWdata  (outWdata),
      .outWe     (outWe),
      .outRdata  (outRdata),
      .mac       (macBus.seq)
   );

   idctMac macUnit (
      .clk  (clk),
      .racc (racc),
      .mac  (macBus.mac)
   );

   blockBuffer #(.Depth(idctPkg::BlockDim * idctPkg::BlockDim)) inBuf (
      .clk   (clk),
      .addr  (inAddr),
      .wdata (inWdata),
      .we    (inWe),
      .rdata (inRdata)
   );

   blockBuffer #(.Depth(idctPkg::BlockDim * idctPkg::BlockDim)) tempBuf (
      .clk   (clk),
      .addr  (tempAddr),
      .wdata (tempWdata),
      .we    (tempWe),
      .rdata (tempRdata)
   );

   blockBuffer #(.Depth(idctPkg::BlockDim * idctPkg::BlockDim)) outBuf (
      .clk   (clk),
      .addr  (outAddr),
      .wdata (outWdata),
      .we    (outWe),
      .rdata (outRdata)
   );

endmodule

// ==== sim/tbIdct.sv ====
// testbench for the 8x8 idct
// directed block tests checked against a two-pass reference model, with a watchdog

module tbIdct;

   localparam int Elems = idctPkg::BlockDim * idctPkg::BlockDim;
   // load, two passes with drain slack, unload and idle turnaround
   localparam int BlockCycles = Elems + 2 * (Elems * idctPkg::BlockDim + 16) + Elems + 8;
   localparam int ResetCycles = 8;
   localparam int WatchdogCycles = 6 * BlockCycles + ResetCycles + 32;

   logic          clk;
   logic          racc;
   logic          start;
   idctPkg::wordT din;
   logic          reading;
   logic          done;
   idctPkg::wordT dout;

   idctPkg::wordT inBlock [Elems];
   idctPkg::wordT expBlock [Elems];
   idctPkg::wordT gotBlock [Elems];

   idct i_idct (
      .clk     (clk),
      .racc    (racc),
      .start   (start),
      .din     (din),
      .reading (reading),
      .done    (done),
      .dout    (dout)
   );

   always #5 clk = ~clk;

   task automatic abortRun(input string reason);
      $display("FAIL: see errors above");
      $fatal(1, "%s", reason);
   endtask

   task automatic checkValue(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
      if (got !== expected)
      begin
         $display("[FAIL] %s: got %h, expected %h", name, got, expected);
         abortRun("stopped at first mismatch");
      end
   endtask

   // rows first, then columns; each sum shifted by PassShift and cut to a word
   task automatic computeReference();
      longint        sum;
      idctPkg::wordT temp [Elems];
      for (int r = 0; r < idctPkg::BlockDim; r++)
         for (int x = 0; x < idctPkg::BlockDim; x++)
         begin
            sum = 0;
            for (int k = 0; k < idctPkg::BlockDim; k++)
               sum += longint'(inBlock[r*8+k]) * longint'(idctPkg::cosTable[x*8+k]);
            temp[r*8+x] = idctPkg::wordT'(sum >>> idctPkg::PassShift);
         end
      for (int y = 0; y < idctPkg::BlockDim; y++)
         for (int x = 0; x < idctPkg::BlockDim; x++)
         begin
            sum = 0;
            for (int k = 0; k < idctPkg::BlockDim; k++)
               sum += longint'(temp[k*8+x]) * longint'(idctPkg::cosTable[y*8+k]);
            expBlock[y*8+x] = idctPkg::wordT'(sum >>> idctPkg::PassShift);
         end
   endtask

   // one start pulse, then exactly 64 cycles of reading
   task automatic loadBlock();
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      for (int n = 0; n < Elems; n++)
      begin
         checkValue("reading", 64'(reading), 64'h1);
         din = inBlock[n];
         @(posedge clk);
         #1;
      end
      din = '0;
      checkValue("reading", 64'(reading), 64'h0);
   endtask

   task automatic collectBlock();
      while (!done)
      begin
         // no second load window while the block is computed
         checkValue("reading", 64'(reading), 64'h0);
         @(posedge clk);
         #1;
      end
      for (int n = 0; n < Elems; n++)
      begin
         checkValue("done", 64'(done), 64'h1);
         checkValue("reading", 64'(reading), 64'h0);
         gotBlock[n] = dout;
         @(posedge clk);
         #1;
      end
      checkValue("done", 64'(done), 64'h0);
   endtask

   task automatic runBlock();
      computeReference();
      loadBlock();
      collectBlock();
      for (int n = 0; n < Elems; n++)
         checkValue($sformatf("dout[%0d]", n), 64'(gotBlock[n]), 64'(expBlock[n]));
   endtask

   task automatic fillRandom();
      logic [31:0] raw;
      for (int n = 0; n < Elems; n++)
      begin
         raw = $urandom;
         inBlock[n] = idctPkg::wordT'($signed(raw[15:0]));
      end
   endtask

   task automatic idleAfterReset();
      repeat (16)
      begin
         checkValue("reading", 64'(reading), 64'h0);
         checkValue("done", 64'(done), 64'h0);
         checkValue("dout", 64'(dout), 64'h0);
         @(posedge clk);
         #1;
      end
   endtask

   task automatic dcBlockTest();
      longint dcValue;
      // both passes scale by the c(0) coefficient only
      dcValue = (((longint'(4096) * 23170) >>> 16) * 23170) >>> 16;
      for (int n = 0; n < Elems; n++)
         inBlock[n] = '0;
      inBlock[0] = 32'sd4096;
      runBlock();
      for (int n = 0; n < Elems; n++)
         checkValue($sformatf("dout[%0d]", n), 64'(gotBlock[n]), 64'(dcValue));
   endtask

   task automatic randomBlockTest();
      fillRandom();
      runBlock();
   endtask

   task automatic backToBackTest();
      fillRandom();
      runBlock();
      fillRandom();
      runBlock();
   endtask

   initial
   begin
      repeat (WatchdogCycles) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles", WatchdogCycles);
      abortRun("watchdog expired");
   end

   initial
   begin
      void'($urandom(32'hcef0));
      clk = 1'b0;
      racc = 1'b1;
      start = 1'b0;
      din = '0;
      repeat (ResetCycles) @(posedge clk);
      #1;
      racc = 1'b0;
      idleAfterReset();
      dcBlockTest();
      randomBlockTest();
      backToBackTest();
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== flist.f ====
hw/idctPkg.sv
hw/idctMacIf.sv
hw/blockBuffer.sv
hw/idctMac.sv
hw/idctSequencer.sv
hw/idct.sv
sim/tbIdct.sv

// ==== Makefile ====
# Verilator flow for the idct testbench

TOP := tbIdct

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f flist.f -o simIdct
	@out=$$(./obj_dir/simIdct); echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir
